//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_ads816x_adc_ctrl
FILELIST   ?= tb.f
PASS_MSG   := Test completed successfully

SIM := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Output goes to the terminal and through grep for the pass line
run: build
	@set -o pipefail 2>/dev/null; ./$(SIM) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

//--- adc_cmd_seq.sv
module adc_cmd_seq (
  input  logic                clk,
  input  logic                resetn,
  input  adc_pkg::cmd_src_t   cmd_src,
  output logic                cmd_buf_rd_en,
  input  logic                trigger,
  output logic                waiting_for_trig,
  output adc_pkg::frame_req_t frame_req,
  input  adc_pkg::frame_rsp_t frame_rsp,
  output adc_pkg::sample_t    sample,
  input  logic                overflow,
  output adc_pkg::err_flags_t errors
);
  import adc_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_DELAY,
    S_TRIG_WAIT,
    S_ADC_RD,
    S_ERROR
  } state_t;

  // Eight channel requests plus one dummy to flush the last result
  localparam logic [3:0] LAST_FRAME = 4'(N_CHANNELS);

  state_t             state;
  state_t             acc_state;   // Where the accepted command leads
  logic [2:0]         opcode;
  logic [COUNT_W-1:0] count;
  logic               ready;
  logic               timed_op;    // NO_OP or ADC_RD carry trig/cont bits
  logic               cmd_done;
  logic               accept;
  logic               read_done;
  logic               wait_trig;
  logic               expect_next;
  logic [COUNT_W-1:0] delay_cnt;
  logic [COUNT_W-1:0] trig_cnt;
  ch_t                order [N_CHANNELS];
  logic [3:0]         frame_idx;   // Frame currently on the wire
  logic [3:0]         next_idx;
  ch_t                req_ch;
  logic               e_unexp;
  logic               e_short;
  logic               e_bad;
  logic               e_under;
  logic               err_any;

  ////////////////////////////////
  // Command decode
  ////////////////////////////////

  assign opcode   = cmd_src.word[31:29];
  assign count    = cmd_src.word[COUNT_W-1:0];
  assign ready    = !cmd_src.empty;
  assign timed_op = (opcode == OP_NO_OP) || (opcode == OP_ADC_RD);

  always_comb begin
    case (opcode)
      OP_NO_OP:   acc_state = cmd_src.word[TRIG_BIT] ? S_TRIG_WAIT : S_DELAY;
      OP_ADC_RD:  acc_state = S_ADC_RD;
      OP_SET_ORD: acc_state = S_IDLE;
      default:    acc_state = S_ERROR; // 001, 011, 101, 110, 111
    endcase
  end

  // Current command has run its course
  always_comb begin
    case (state)
      S_IDLE:      cmd_done = 1'b1;
      S_DELAY:     cmd_done = (delay_cnt == '0);
      S_TRIG_WAIT: cmd_done = (trig_cnt == '0);
      S_ADC_RD:    cmd_done = read_done && (wait_trig ? (trig_cnt == '0) : (delay_cnt == '0));
      default:     cmd_done = 1'b0;
    endcase
  end

  assign accept           = cmd_done && ready && resetn; // No pop while held in reset
  assign cmd_buf_rd_en    = accept;
  assign waiting_for_trig = (state == S_TRIG_WAIT);

  always_ff @(posedge clk) begin
    if (!resetn)        state <= S_IDLE;
    else if (err_any)   state <= S_ERROR;   // Left only through reset
    else if (accept)    state <= acc_state;
    else if (cmd_done)  state <= S_IDLE;    // Buffer ran dry with no follow-up promised
    else if (read_done) state <= wait_trig ? S_TRIG_WAIT : S_DELAY; // Finish the wait
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
    end else if (accept) begin
      wait_trig   <= timed_op && cmd_src.word[TRIG_BIT];
      expect_next <= timed_op && cmd_src.word[CONT_BIT]; // SET_ORD never promises more
    end
  end

  ////////////////////////////////
  // Delay timer and trigger count
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn)                   delay_cnt <= '0;
    else if (accept && timed_op)   delay_cnt <= cmd_src.word[TRIG_BIT] ? '0 : count;
    else if (delay_cnt != '0)      delay_cnt <= delay_cnt - 1'b1; // Also runs under a read
  end

  always_ff @(posedge clk) begin
    if (!resetn)                       trig_cnt <= '0;
    else if (accept && timed_op)       trig_cnt <= cmd_src.word[TRIG_BIT] ? count : '0;
    else if (trigger && trig_cnt != '0) trig_cnt <= trig_cnt - 1'b1;
  end

  // Sample order table starts as identity
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < N_CHANNELS; i++) order[i] <= ch_t'(i);
    end else if (accept && opcode == OP_SET_ORD) begin
      for (int i = 0; i < N_CHANNELS; i++) order[i] <= cmd_src.word[3*i +: 3];
    end
  end

  ////////////////////////////////
  // Frame issue and sample return
  ////////////////////////////////

  assign next_idx = accept ? 4'd0 : frame_idx + 4'd1;
  assign req_ch   = (next_idx == LAST_FRAME) ? ch_t'(0) : order[next_idx[2:0]]; // Dummy on ch 0

  // First frame with the command and then one per done until the dummy
  assign frame_req.start = (accept && opcode == OP_ADC_RD)
                           || (state == S_ADC_RD && frame_rsp.done && frame_idx != LAST_FRAME);
  assign frame_req.mosi_word = {2'b10, req_ch, {(FRAME_BITS - 5){1'b0}}}; // OTF sample request

  always_ff @(posedge clk) begin
    if (!resetn)              frame_idx <= '0;
    else if (frame_req.start) frame_idx <= next_idx;
  end

  // Replies lag one frame, so frame 0 carries nothing useful
  assign sample.valid = (state == S_ADC_RD) && frame_rsp.done && (frame_idx != 4'd0);
  assign sample.data  = frame_rsp.miso_word;
  assign read_done    = (state == S_ADC_RD) && frame_rsp.done && (frame_idx == LAST_FRAME);

  ////////////////////////////////
  // Error flags
  ////////////////////////////////

  assign e_unexp = trigger && (state != S_TRIG_WAIT) && (trig_cnt == '0);
  assign e_short = (state == S_ADC_RD) && !read_done && !wait_trig && (delay_cnt == '0);
  assign e_bad   = accept && (acc_state == S_ERROR);
  assign e_under = cmd_done && expect_next && !ready;
  assign err_any = e_unexp || e_short || e_bad || e_under || overflow;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      errors <= '0;
    end else begin
      errors.unexp_trig        <= errors.unexp_trig | e_unexp;        // Sticky
      errors.delay_too_short   <= errors.delay_too_short | e_short;
      errors.bad_cmd           <= errors.bad_cmd | e_bad;
      errors.cmd_buf_underflow <= errors.cmd_buf_underflow | e_under;
      errors.data_buf_overflow <= overflow;                           // Packer keeps it sticky
    end
  end

  // Frame replies only come back for reads this block started
  a_done_in_read: assert property (@(posedge clk) disable iff (!resetn)
    frame_rsp.done |-> (state == S_ADC_RD) || (state == S_ERROR));

endmodule

//--- adc_ctrl_tests.txt
# test <trigger pulses> <data_buf_full held> <flags hex: unexp,short,bad,under,ovf> <cmds left>
# cmd / late <command word hex>, word <expected data word hex>, end runs the test
test 0 0 00 0
cmd 40000400
word A111A000
word A333A222
word A555A444
word A777A666
end
test 0 0 00 0
cmd 80053977
cmd 40000400
word A666A777
word A444A555
word A222A333
word A000A111
end
test 3 0 00 0
cmd 10000003
cmd 40000400
word A111A000
word A333A222
word A555A444
word A777A666
end
test 1 0 10 1
late 40000400
end
test 0 0 04 0
cmd E0000000
end
test 0 0 02 0
cmd 0800000A
end
test 0 0 08 0
cmd 40000005
end
test 0 1 01 0
cmd 40000400
end

//--- adc_pkg.sv
package adc_pkg;

  ////////////////////////////////
  // ADC model and clock timing
  ////////////////////////////////

  localparam integer ADS_MODEL_ID = 8;          // 8 ADS8168, 7 ADS8167, 6 ADS8166
  localparam integer SPI_CLK_HZ   = 20_000_000; // clk doubles as SCK
  localparam integer CLK_MHZ      = SPI_CLK_HZ / 1_000_000;

  // Conversion and cycle times of the selected part, in ns
  localparam integer T_CONV_NS  = (ADS_MODEL_ID == 8) ? 660  :
                                  (ADS_MODEL_ID == 7) ? 1200 : 2500;
  localparam integer T_CYCLE_NS = (ADS_MODEL_ID == 8) ? 1000 :
                                  (ADS_MODEL_ID == 7) ? 2000 : 4000;

  // Same times in clk cycles, rounded up
  localparam integer N_CONV_CYCLES  = (T_CONV_NS * CLK_MHZ + 999) / 1000;
  localparam integer N_CYCLE_CYCLES = (T_CYCLE_NS * CLK_MHZ + 999) / 1000;

  localparam integer FRAME_BITS = 16; // On-the-fly request length

  // n_cs high time covers conversion and the rest of the sample cycle
  localparam integer CS_FLOOR_A   = (N_CONV_CYCLES > N_CYCLE_CYCLES - FRAME_BITS) ?
                                    N_CONV_CYCLES : N_CYCLE_CYCLES - FRAME_BITS;
  localparam integer CS_HIGH_CALC = (CS_FLOOR_A > 3) ? CS_FLOOR_A : 3;
  localparam logic [7:0] CS_HIGH_CYCLES = 8'(CS_HIGH_CALC); // 14 for ADS8168

  ////////////////////////////////
  // Command word layout
  ////////////////////////////////

  localparam integer N_CHANNELS = 8;

  localparam logic [2:0] OP_NO_OP   = 3'b000;
  localparam logic [2:0] OP_ADC_RD  = 3'b010;
  localparam logic [2:0] OP_SET_ORD = 3'b100;

  localparam integer TRIG_BIT = 28; // Wait on trigger pulses instead of delay
  localparam integer CONT_BIT = 27; // Another command must follow
  localparam integer COUNT_W  = 26; // Delay cycles or trigger count

  typedef logic [2:0] ch_t;

  ////////////////////////////////
  // Bundles between blocks
  ////////////////////////////////

  typedef struct packed {
    logic [31:0] word;  // FWFT head of command buffer
    logic        empty;
  } cmd_src_t;

  typedef struct packed {
    logic        wr_en;
    logic [31:0] word;  // Earlier sample in [15:0]
  } data_sink_t;

  typedef struct packed {
    logic unexp_trig;
    logic delay_too_short;
    logic bad_cmd;
    logic cmd_buf_underflow;
    logic data_buf_overflow;
  } err_flags_t;

  typedef struct packed {
    logic n_cs;
    logic mosi;
  } spi_pins_t;

  typedef struct packed {
    logic                  start;
    logic [FRAME_BITS-1:0] mosi_word;
  } frame_req_t;

  typedef struct packed {
    logic                  done;
    logic [FRAME_BITS-1:0] miso_word;
  } frame_rsp_t;

  typedef struct packed {
    logic                  valid;
    logic [FRAME_BITS-1:0] data;
  } sample_t;

endpackage

//--- adc_sample_pack.sv
module adc_sample_pack (
  input  logic                clk,
  input  logic                resetn,
  input  adc_pkg::sample_t    sample,
  input  logic                data_buf_full,
  output adc_pkg::data_sink_t data_sink,
  output logic                overflow
);
  import adc_pkg::*;

  logic [FRAME_BITS-1:0]   first_q;    // Earlier sample of the pair
  logic                    have_first; // Toggles per sample
  logic                    pend;       // Pair complete and word goes out now
  logic [2*FRAME_BITS-1:0] word_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      have_first <= 1'b0;
      pend       <= 1'b0;
    end else begin
      pend <= sample.valid && have_first;
      if (sample.valid) have_first <= !have_first;
    end
  end

  always_ff @(posedge clk) begin
    if (sample.valid && !have_first) first_q <= sample.data;
    if (sample.valid && have_first)  word_q  <= {sample.data, first_q}; // Later one on top
  end

  // A full buffer turns the write into a sticky overflow
  always_ff @(posedge clk) begin
    if (!resetn)                    overflow <= 1'b0;
    else if (pend && data_buf_full) overflow <= 1'b1;
  end

  assign data_sink.wr_en = pend && !data_buf_full;
  assign data_sink.word  = word_q;

  // Sequencer halts on overflow, so no later pair may complete
  a_halt_after_ovf: assert property (@(posedge clk) disable iff (!resetn)
    overflow |-> !data_sink.wr_en);

endmodule

//--- adc_spi_frame.sv
module adc_spi_frame (
  input  logic                clk,
  input  logic                resetn,
  input  adc_pkg::frame_req_t frame_req,
  output adc_pkg::frame_rsp_t frame_rsp,
  output adc_pkg::spi_pins_t  spi,
  input  logic                miso
);
  import adc_pkg::*;

  localparam integer BIT_W = $clog2(FRAME_BITS + 1);

  logic [7:0]            cs_cnt;    // n_cs high phase, CS_HIGH_CYCLES down to 1
  logic                  cs_expire; // Last high cycle before n_cs falls
  logic [BIT_W-1:0]      bit_cnt;   // FRAME_BITS down to 1 while n_cs low
  logic [FRAME_BITS-1:0] mosi_sr;
  logic [FRAME_BITS-1:0] miso_sr;
  logic                  n_cs;
  logic                  done;
  logic                  active;

  assign active    = (cs_cnt != '0) || (bit_cnt != '0);
  assign cs_expire = (cs_cnt == 8'd1);

  ////////////////////////////////
  // Chip select timing
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      cs_cnt <= '0;
    end else if (frame_req.start) begin
      cs_cnt <= CS_HIGH_CYCLES; // Conversion time before clocking
    end else if (cs_cnt != '0) begin
      cs_cnt <= cs_cnt - 8'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      bit_cnt <= '0;
    end else if (cs_expire) begin
      bit_cnt <= BIT_W'(FRAME_BITS);
    end else if (bit_cnt != '0) begin
      bit_cnt <= bit_cnt - 1'b1;
    end
  end

  // n_cs low for exactly FRAME_BITS cycles
  always_ff @(posedge clk) begin
    if (!resetn)                      n_cs <= 1'b1;
    else if (cs_expire)               n_cs <= 1'b0;
    else if (bit_cnt == BIT_W'(1))    n_cs <= 1'b1; // Rises with done
  end

  always_ff @(posedge clk) begin
    if (!resetn) done <= 1'b0;
    else         done <= (bit_cnt == BIT_W'(1)); // One-cycle strobe after last bit
  end

  ////////////////////////////////
  // Data shifters
  ////////////////////////////////

  // Request word latched at start, MSB first once n_cs is low
  always_ff @(posedge clk) begin
    if (frame_req.start) begin
      mosi_sr <= frame_req.mosi_word;
    end else if (bit_cnt != '0) begin
      mosi_sr <= {mosi_sr[FRAME_BITS-2:0], 1'b0};
    end
  end

  // MISO sampled at the end of every low cycle
  always_ff @(posedge clk) begin
    if (bit_cnt != '0) begin
      miso_sr <= {miso_sr[FRAME_BITS-2:0], miso};
    end
  end

  assign spi.n_cs = n_cs;
  assign spi.mosi = mosi_sr[FRAME_BITS-1] & ~n_cs; // Quiet low outside the frame

  assign frame_rsp.done      = done;
  assign frame_rsp.miso_word = miso_sr; // Complete during the done cycle

  // Back-to-back frames may start in the done cycle, never earlier
  a_no_overlap: assert property (@(posedge clk) disable iff (!resetn)
    frame_req.start |-> !active);

endmodule

//--- ads816x_adc_ctrl.sv
module ads816x_adc_ctrl (
  input  logic                clk,
  input  logic                resetn,
  input  adc_pkg::cmd_src_t   cmd_src,
  output logic                cmd_buf_rd_en,
  input  logic                data_buf_full,
  output adc_pkg::data_sink_t data_sink,
  input  logic                trigger,
  output logic                waiting_for_trig,
  output adc_pkg::err_flags_t errors,
  output adc_pkg::spi_pins_t  spi,
  input  logic                miso
);
  import adc_pkg::*;

  frame_req_t frame_req; // Sequencer to SPI engine
  frame_rsp_t frame_rsp; // SPI engine back, one per frame
  sample_t    sample;    // Realigned ADC results
  logic       overflow;  // Packer hit a full data buffer

  // Command flow, timers and error tracking
  adc_cmd_seq u_cmd_seq (
    .clk              (clk),
    .resetn           (resetn),
    .cmd_src          (cmd_src),
    .cmd_buf_rd_en    (cmd_buf_rd_en),
    .trigger          (trigger),
    .waiting_for_trig (waiting_for_trig),
    .frame_req        (frame_req),
    .frame_rsp        (frame_rsp),
    .sample           (sample),
    .overflow         (overflow),
    .errors           (errors)
  );

  // Single 16-bit OTF frame on clk as SCK
  adc_spi_frame u_spi_frame (
    .clk       (clk),
    .resetn    (resetn),
    .frame_req (frame_req),
    .frame_rsp (frame_rsp),
    .spi       (spi),
    .miso      (miso)
  );

  adc_sample_pack u_sample_pack (
    .clk           (clk),
    .resetn        (resetn),
    .sample        (sample),
    .data_buf_full (data_buf_full),
    .data_sink     (data_sink),
    .overflow      (overflow)
  );

endmodule

//--- tb.f
adc_pkg.sv
adc_cmd_seq.sv
adc_spi_frame.sv
adc_sample_pack.sv
ads816x_adc_ctrl.sv
tb_ads816x_adc_ctrl.sv

//--- tb_ads816x_adc_ctrl.sv
module tb_ads816x_adc_ctrl;
  import adc_pkg::*;

  localparam integer WAIT_LIMIT   = 5000; // Cycles before a wait gives up
  localparam integer QUIET_CYCLES = 300;  // Watch window for stray words or flags

  logic        clk = 1'b0;
  logic        resetn = 1'b0;
  cmd_src_t    cmd_src = {32'h0, 1'b1}; // Empty buffer
  logic        cmd_buf_rd_en;
  logic        data_buf_full = 1'b0;
  data_sink_t  data_sink;
  logic        trigger = 1'b0;
  logic        waiting_for_trig;
  err_flags_t  flags;
  spi_pins_t   spi;
  logic        miso = 1'b0;

  logic [31:0] buf_q [$];   // Command buffer contents
  logic [31:0] cmd_list [$];
  logic [31:0] late_list [$];
  logic [31:0] exp_q [$];
  logic [31:0] got_q [$];   // Words written by the DUT
  logic        pop_pend = 1'b0;
  logic [15:0] lfsr = 16'd38457;
  int          err_cnt = 0;
  int          test_no = 0;
  int          n_trig;
  int          left;
  logic        hold_full;
  logic [4:0]  exp_flags;
  logic [15:0] rx_sr;
  logic [15:0] tx_word;
  int          bit_idx;

  ads816x_adc_ctrl u_ads816x_adc_ctrl (
    .clk              (clk),
    .resetn           (resetn),
    .cmd_src          (cmd_src),
    .cmd_buf_rd_en    (cmd_buf_rd_en),
    .data_buf_full    (data_buf_full),
    .data_sink        (data_sink),
    .trigger          (trigger),
    .waiting_for_trig (waiting_for_trig),
    .errors           (flags),
    .spi              (spi),
    .miso             (miso)
  );

  initial begin
    forever #50 clk = ~clk; // Period 100
  end

  //////////////////////////////
  // Buffer and ADC models
  //////////////////////////////

  // Pops and written words are taken at negedge
  always @(negedge clk) begin
    pop_pend = cmd_buf_rd_en; // A pop under reset would lose a command
    if (resetn && data_sink.wr_en) got_q.push_back(data_sink.word);
  end

  // FWFT head follows the pop one cycle later
  always @(posedge clk) begin
    #5;
    if (pop_pend && buf_q.size() > 0) void'(buf_q.pop_front());
    cmd_src.empty = (buf_q.size() == 0);
    cmd_src.word  = (buf_q.size() == 0) ? 32'h0 : buf_q[0];
  end

  // ADC answers the previous frame's channel with the MSB first
  always @(posedge clk) begin
    #5;
    if (!resetn) begin
      bit_idx = 0;
      tx_word = 16'h0;
      miso    = 1'b0;
    end else if (!spi.n_cs) begin
      rx_sr   = {rx_sr[14:0], spi.mosi};
      miso    = tx_word[15 - bit_idx];
      bit_idx = bit_idx + 1;
    end else if (bit_idx == 16) begin
      tx_word = 16'hA000 + 16'h0111 * rx_sr[13:11]; // Channel field of request
      bit_idx = 0;
      miso    = 1'b0;
    end
  end

  // Galois LFSR stepped once per bit taken
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v    = (v << 1) | lfsr[0];
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  //////////////////////////////
  // Test steps
  //////////////////////////////

  task automatic pulse_triggers(input int n, input bit wait_first);
    int t;
    int gap;
    for (int i = 0; i < n; i++) begin
      t = 0;
      while (wait_first && !waiting_for_trig && t < WAIT_LIMIT) begin
        @(posedge clk);
        #5;
        t++;
      end
      if (t >= WAIT_LIMIT) begin
        $display("Timeout: waiting_for_trig never rose in test %0d", test_no);
        err_cnt++;
      end
      gap = 2 + take_bits(4);
      repeat (gap) @(posedge clk);
      #5 trigger = 1'b1;
      @(posedge clk);
      #5 trigger = 1'b0;
    end
  endtask

  task automatic run_test();
    int t;
    test_no++;
    @(posedge clk);
    #5;
    resetn        = 1'b0;
    trigger       = 1'b0;
    data_buf_full = hold_full;
    got_q.delete();
    buf_q.delete();
    @(posedge clk);
    #2;
    foreach (cmd_list[i]) buf_q.push_back(cmd_list[i]); // Loaded under reset
    @(posedge clk);
    #5 resetn = 1'b1;
    pulse_triggers(n_trig, cmd_list.size() > 0);
    foreach (late_list[i]) begin
      @(posedge clk);
      #2 buf_q.push_back(late_list[i]);
    end
    t = 0;
    while (!(got_q.size() >= exp_q.size() && buf_q.size() == left && flags == exp_flags)
           && t < WAIT_LIMIT) begin
      @(posedge clk);
      #5;
      t++;
    end
    if (t >= WAIT_LIMIT) begin
      $display("Timeout: test %0d never reached its expected end state", test_no);
      err_cnt++;
    end
    repeat (QUIET_CYCLES) @(posedge clk); // Let stray activity show up
    if (got_q.size() != exp_q.size()) begin
      $display("[FAIL] %0t: test %0d wrote %0d words, expected %0d",
               $time, test_no, got_q.size(), exp_q.size());
      err_cnt++;
    end
    foreach (exp_q[i]) begin
      if (i < got_q.size() && got_q[i] != exp_q[i]) begin
        $display("[FAIL] %0t: test %0d word %0d is %h, expected %h",
                 $time, test_no, i, got_q[i], exp_q[i]);
        err_cnt++;
      end
    end
    if (flags != exp_flags) begin
      $display("[FAIL] %0t: test %0d flags %b, expected %b", $time, test_no, flags, exp_flags);
      err_cnt++;
    end
    if (buf_q.size() != left) begin
      $display("[FAIL] %0t: test %0d left %0d commands, expected %0d",
               $time, test_no, buf_q.size(), left);
      err_cnt++;
    end
    // All trigger counts are used up by now
    if (waiting_for_trig !== 1'b0) begin
      $display("[FAIL] %0t: test %0d still waiting for a trigger", $time, test_no);
      err_cnt++;
    end
    cmd_list.delete();
    late_list.delete();
    exp_q.delete();
  endtask

  //////////////////////////////
  // Vector file reader
  //////////////////////////////

  initial begin
    int          fd;
    string       line;
    string       kw;
    logic [31:0] val;
    int          hf;
    fd = $fopen("adc_ctrl_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test vector file adc_ctrl_tests.txt");
      err_cnt++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() == 0 || line[0] == "#") continue; // Comment or blank
        if ($sscanf(line, "%s", kw) != 1) continue;
        if (kw == "test") begin
          void'($sscanf(line, "%s %d %d %h %d", kw, n_trig, hf, exp_flags, left));
          hold_full = (hf != 0);
        end else if (kw == "cmd") begin
          void'($sscanf(line, "%s %h", kw, val));
          cmd_list.push_back(val);
        end else if (kw == "late") begin
          void'($sscanf(line, "%s %h", kw, val));
          late_list.push_back(val);
        end else if (kw == "word") begin
          void'($sscanf(line, "%s %h", kw, val));
          exp_q.push_back(val);
        end else if (kw == "end") begin
          run_test();
        end
      end
      $fclose(fd);
    end
    $display("Tests run: %0d, errors: %0d", test_no, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
